//--- tb/radio_stimulus.txt
// op a b c d, hex. 1 write addr data, 2 read addr rb_data, 3 run rx tx gpio leds
// 4 sample {adc,bb_rx} {tx,bb_tx} {rx0,rx1} {0,tx}, 5 pins gpio_in misc_in misc ddr, f end
1 A0 11110000 0 0
1 A1 22220001 0 0
1 A2 44440002 0 0
1 A3 88880003 0 0
1 A4 0000FFFF 0 0
1 A5 CAFE0005 0 0
1 A6 00000001 0 0
1 A7 FFFFFFFC 0 0
1 A8 00000002 0 0
1 A9 00000007 0 0
3 1 0 22220001 4
3 0 2 44440002 2
3 2 1 88880003 7
3 0 0 11110000 1
5 A5A55A5A 12345678 CAFE0005 0000FFFF
2 0 A5A55A5A11110000 0 0
2 1 12345678CAFE0005 0 0
2 2 0000FFFF00000001 0 0
2 3 0 0 0
2 A0 0 0 0
1 E0 0010FFF0 0 0
1 E1 00000001 0 0
1 F0 7FFF0001 0 0
1 F1 00000003 0 0
1 D0 01000200 0 0
1 D1 00000002 0 0
4 12340005DEADBEEF 0003FFFE11112222 001512247FFA1235 0000000000FD01FE
4 80007FFFDEADBEEF 8000FFFF11112222 800F7FF000008001 00000000810001FF
3 1 1 88880003 7
4 12340005CAFEF00D 0003FFFE00020004 CAFEF00DCAFEF00D 0000000000FE0204
3 2 2 88880003 7
4 12340005DEADBEEF 0003FFFE11112222 001512247FFA1235 0000000000FD01FE
f 0 0 0 0

//--- filelist.f
common/radio_pkg.sv
db_control/db_settings_regs.sv
db_control/db_atr_gpio.sv
fe_control/fe_iq_corrector.sv
fe_control/fe_control.sv
hw/radio_slot_core.sv
tb/tb_radio_slot_core.sv

//--- Makefile
# Verilator flow for the radio slot testbench, run from this directory

TOP = tb_radio_slot_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

# pass only when the simulation prints the pass message
sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

//--- tb/tb_radio_slot_core.sv
`default_nettype none
// ------------------------------
// self-checking testbench for one radio slot, replays tb/radio_stimulus.txt
// run from the project root through the Makefile
// ------------------------------

module tb_radio_slot_core
   import radio_pkg::*;
;
   localparam int        CLK_PERIOD     = 40;
   localparam int        MAX_RECS       = 64;
   localparam int        REC_WORDS      = 5;        // op a b c d
   localparam set_addr_t RX_FE_BASE     = 8'd224;   // dut defaults
   localparam set_addr_t TX_FE_BASE     = 8'd208;
   localparam set_addr_t FE_CHAN_OFFSET = 8'd16;

   localparam logic [3:0] OP_WRITE  = 4'h1;
   localparam logic [3:0] OP_READ   = 4'h2;
   localparam logic [3:0] OP_RUN    = 4'h3;
   localparam logic [3:0] OP_SAMPLE = 4'h4;
   localparam logic [3:0] OP_PINS   = 4'h5;
   localparam logic [3:0] OP_END    = 4'hf;

   logic          radio_clk = 1'b0;
   logic          i_rst_n;
   set_bus_t      i_set;
   rb_req_t       i_rb;
   word_t         i_gpio_in;
   word_t         i_misc_in;
   logic [1:0]    i_run_rx;
   logic [1:0]    i_run_tx;
   logic          i_rx_stb;
   sample_t       i_rx_sample;
   sample_t       i_bb_rx;
   sample_t       i_tx_data;
   sample_t       i_bb_tx;
   word_t         o_gpio_out;
   word_t         o_gpio_ddr;
   led_t          o_leds;
   word_t         o_misc_out;
   logic          o_rb_stb;
   rb_data_t      o_rb_data;
   logic          o_rx_stb;
   sample_t [1:0] o_rx_data;
   sample_t       o_tx;

   logic [63:0]           stim [0:MAX_RECS*REC_WORDS-1];
   int                    num_recs  = 0;
   logic                  loaded    = 1'b0;   // record count known
   int                    test_err  = 0;      // errors in the running test
   int                    pass_cnt  = 0;
   int                    fail_cnt  = 0;
   word_t      [2:0]      fe_dc;              // model of fe regs, rx0 rx1 tx
   logic [2:0] [1:0]      fe_ctrl;

   radio_slot_core radio_slot_core_i (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n), .i_set(i_set), .i_rb(i_rb),
      .i_gpio_in(i_gpio_in), .i_misc_in(i_misc_in), .i_run_rx(i_run_rx),
      .i_run_tx(i_run_tx), .i_rx_stb(i_rx_stb), .i_rx_sample(i_rx_sample),
      .i_bb_rx(i_bb_rx), .i_tx_data(i_tx_data), .i_bb_tx(i_bb_tx),
      .o_gpio_out(o_gpio_out), .o_gpio_ddr(o_gpio_ddr), .o_leds(o_leds),
      .o_misc_out(o_misc_out), .o_rb_stb(o_rb_stb), .o_rb_data(o_rb_data),
      .o_rx_stb(o_rx_stb), .o_rx_data(o_rx_data), .o_tx(o_tx)
   );

   always #(CLK_PERIOD/2) radio_clk = ~radio_clk;

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
         test_err++;
      end
   endtask

   // swap, negate i, dc add, all in 16 bits
   function automatic sample_t iq_correct(input sample_t s, input word_t dc,
                                          input logic [1:0] ctrl);
      logic [15:0] si;
      logic [15:0] sq;
      logic [15:0] tmp;
      si = s[31:16];
      sq = s[15:0];
      if (ctrl[0]) begin
         tmp = si;
         si  = sq;
         sq  = tmp;
      end
      if (ctrl[1]) si = ~si + 16'd1;   // two's complement
      si = si + dc[31:16];
      sq = sq + dc[15:0];
      return {si, sq};
   endfunction

   // track fe register writes, rx channels then tx
   task automatic shadow_fe(input set_addr_t addr, input word_t data);
      set_addr_t base;
      for (int ch = 0; ch < 3; ch++) begin
         base = (ch == 2) ? TX_FE_BASE : set_addr_t'(RX_FE_BASE + ch * FE_CHAN_OFFSET);
         if (addr == base + SR_FE_DC) fe_dc[ch] = data;
         if (addr == base + SR_FE_CTRL) fe_ctrl[ch] = data[1:0];
      end
   endtask

   task automatic bus_write(input set_addr_t addr, input word_t data);
      i_set.stb  = 1'b1;
      i_set.addr = addr;
      i_set.data = data;
      shadow_fe(addr, data);
      @(negedge radio_clk);
      i_set.stb = 1'b0;
   endtask

   // answer lands exactly one edge after the request
   task automatic bus_read(input set_addr_t addr, input rb_data_t exp);
      i_rb.stb  = 1'b1;
      i_rb.addr = addr;
      @(negedge radio_clk);
      i_rb.stb = 1'b0;
      check_value("o_rb_stb", 64'(o_rb_stb), 64'd1);
      check_value("o_rb_data", o_rb_data, exp);
   endtask

   task automatic set_run(input logic [1:0] rx, input logic [1:0] tx,
                          input word_t exp_gpio, input led_t exp_leds);
      i_run_rx = rx;
      i_run_tx = tx;
      @(negedge radio_clk);   // one edge to the pins
      check_value("o_gpio_out", 64'(o_gpio_out), 64'(exp_gpio));
      check_value("o_leds", 64'(o_leds), 64'(exp_leds));
   endtask

   task automatic set_pins(input word_t gpio_in, input word_t misc_in,
                           input word_t exp_misc, input word_t exp_ddr);
      i_gpio_in = gpio_in;
      i_misc_in = misc_in;
      repeat (2) @(negedge radio_clk);   // misc in stage settles
      check_value("o_misc_out", 64'(o_misc_out), 64'(exp_misc));
      check_value("o_gpio_ddr", 64'(o_gpio_ddr), 64'(exp_ddr));
   endtask

   task automatic send_sample(input logic [63:0] rx_in, input logic [63:0] tx_in,
                              input logic [63:0] exp_rx, input logic [63:0] exp_tx);
      sample_t model_rx0;
      sample_t model_rx1;
      sample_t model_tx;
      i_rx_stb    = 1'b1;
      i_rx_sample = rx_in[63:32];
      i_bb_rx     = rx_in[31:0];
      i_tx_data   = tx_in[63:32];
      i_bb_tx     = tx_in[31:0];
      // override keyed on channel 0 flags only
      model_rx0 = i_run_rx[0] ? i_bb_rx : iq_correct(i_rx_sample, fe_dc[0], fe_ctrl[0]);
      model_rx1 = i_run_rx[0] ? i_bb_rx : iq_correct(i_rx_sample, fe_dc[1], fe_ctrl[1]);
      model_tx  = iq_correct(i_run_tx[0] ? i_bb_tx : i_tx_data, fe_dc[2], fe_ctrl[2]);
      @(negedge radio_clk);
      i_rx_stb = 1'b0;
      check_value("o_rx_stb", 64'(o_rx_stb), 64'd1);
      check_value("o_rx_data[0]", 64'(o_rx_data[0]), 64'(exp_rx[63:32]));
      check_value("o_rx_data[1]", 64'(o_rx_data[1]), 64'(exp_rx[31:0]));
      check_value("o_tx", 64'(o_tx), 64'(exp_tx[31:0]));
      check_value("o_rx_data[0] model", 64'(o_rx_data[0]), 64'(model_rx0));
      check_value("o_rx_data[1] model", 64'(o_rx_data[1]), 64'(model_rx1));
      check_value("o_tx model", 64'(o_tx), 64'(model_tx));
   endtask

   task automatic finish_test(input int num, input string name);
      if (test_err == 0) pass_cnt++;
      else fail_cnt++;
      $display("test %0d %s %s", num, name, (test_err == 0) ? "passed" : "failed");
      test_err = 0;
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      int          base;
      logic [3:0]  op;
      i_rst_n     = 1'b0;
      i_set       = '0;
      i_rb        = '0;
      i_gpio_in   = '0;
      i_misc_in   = '0;
      i_run_rx    = '0;
      i_run_tx    = '0;
      i_rx_stb    = 1'b0;
      i_rx_sample = '0;
      i_bb_rx     = '0;
      i_tx_data   = '0;
      i_bb_tx     = '0;
      fe_dc       = '0;   // fe regs come out of reset zero
      fe_ctrl     = '0;
      $readmemh("tb/radio_stimulus.txt", stim);
      while (num_recs < MAX_RECS && stim[num_recs*REC_WORDS][3:0] != OP_END) num_recs++;
      loaded = 1'b1;
      repeat (8) @(negedge radio_clk);
      i_rst_n = 1'b1;
      check_value("o_gpio_ddr", 64'(o_gpio_ddr), 64'd0);   // all pins inputs
      check_value("o_rb_stb", 64'(o_rb_stb), 64'd0);
      check_value("o_rx_stb", 64'(o_rx_stb), 64'd0);
      finish_test(0, "reset state");
      if (num_recs == MAX_RECS) begin
         $display("stimulus file has no end marker");
         fail_cnt++;
      end
      for (int rec = 0; rec < num_recs && num_recs < MAX_RECS; rec++) begin
         base = rec * REC_WORDS;
         op   = stim[base][3:0];
         case (op)
            OP_WRITE:  bus_write(stim[base+1][7:0], stim[base+2][31:0]);
            OP_READ:   bus_read(stim[base+1][7:0], stim[base+2]);
            OP_RUN:    set_run(stim[base+1][1:0], stim[base+2][1:0],
                               stim[base+3][31:0], stim[base+4][2:0]);
            OP_SAMPLE: send_sample(stim[base+1], stim[base+2], stim[base+3], stim[base+4]);
            OP_PINS:   set_pins(stim[base+1][31:0], stim[base+2][31:0],
                                stim[base+3][31:0], stim[base+4][31:0]);
            default: begin
               $display("stimulus line %0d has unknown op %h", rec + 1, op);
               test_err++;
            end
         endcase
         finish_test(rec + 1, $sformatf("op %h", op));
      end
      $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && num_recs > 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // watchdog, 20 cycles per stimulus line plus reset
   initial begin
      wait (loaded);
      #((num_recs * 20 + 16) * CLK_PERIOD);
      $display("timeout, stimulus did not complete in time");
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/radio_slot_core.sv
`default_nettype none
// ----------------------------
// one daughterboard slot on the radio clock, db control plus front end
// ----------------------------

module radio_slot_core
   import radio_pkg::*;
#(
   parameter set_addr_t SR_DB_BASE        = 8'd160,
   parameter set_addr_t SR_RX_FE_BASE     = 8'd224,
   parameter set_addr_t SR_TX_FE_BASE     = 8'd208,
   parameter set_addr_t SR_FE_CHAN_OFFSET = 8'd16,
   parameter int        NUM_CHANNELS      = 2
) (
   input  wire                        radio_clk,
   input  wire                        i_rst_n,
   // settings bus, single master
   input  wire set_bus_t              i_set,
   input  wire rb_req_t               i_rb,
   // pins
   input  wire word_t                 i_gpio_in,
   input  wire word_t                 i_misc_in,
   // channel run flags, levels
   input  wire [NUM_CHANNELS-1:0]     i_run_rx,
   input  wire [NUM_CHANNELS-1:0]     i_run_tx,
   // samples
   input  wire                        i_rx_stb,
   input  wire sample_t               i_rx_sample,
   input  wire sample_t               i_bb_rx,
   input  wire sample_t               i_tx_data,
   input  wire sample_t               i_bb_tx,
   output word_t                      o_gpio_out,
   output word_t                      o_gpio_ddr,
   output led_t                       o_leds,
   output word_t                      o_misc_out,
   output logic                       o_rb_stb,
   output rb_data_t                   o_rb_data,
   output logic                       o_rx_stb,
   output sample_t [NUM_CHANNELS-1:0] o_rx_data,
   output sample_t                    o_tx
);

   word_t [3:0] gpio_bank;   // atr banks from the register file
   led_t  [3:0] led_bank;

   db_settings_regs #(
      .SR_DB_BASE(SR_DB_BASE)
   ) db_settings_regs_i (
      .radio_clk   (radio_clk),
      .i_rst_n     (i_rst_n),
      .i_set       (i_set),
      .i_rb        (i_rb),
      .i_gpio_in   (i_gpio_in),
      .i_misc_in   (i_misc_in),
      .i_gpio_out  (o_gpio_out),
      .i_leds      (o_leds),
      .o_gpio_bank (gpio_bank),
      .o_led_bank  (led_bank),
      .o_gpio_ddr  (o_gpio_ddr),
      .o_misc_out  (o_misc_out),
      .o_rb_stb    (o_rb_stb),
      .o_rb_data   (o_rb_data)
   );

   db_atr_gpio #(
      .NUM_CHANNELS(NUM_CHANNELS)
   ) db_atr_gpio_i (
      .radio_clk   (radio_clk),
      .i_rst_n     (i_rst_n),
      .i_run_rx    (i_run_rx),
      .i_run_tx    (i_run_tx),
      .i_gpio_bank (gpio_bank),
      .i_led_bank  (led_bank),
      .o_gpio_out  (o_gpio_out),
      .o_leds      (o_leds)
   );

   // override keyed on channel 0 only
   fe_control #(
      .SR_RX_FE_BASE     (SR_RX_FE_BASE),
      .SR_TX_FE_BASE     (SR_TX_FE_BASE),
      .SR_FE_CHAN_OFFSET (SR_FE_CHAN_OFFSET),
      .NUM_CHANNELS      (NUM_CHANNELS)
   ) fe_control_i (
      .radio_clk   (radio_clk),
      .i_rst_n     (i_rst_n),
      .i_set       (i_set),
      .i_rx_stb    (i_rx_stb),
      .i_rx_sample (i_rx_sample),
      .i_bb_rx     (i_bb_rx),
      .i_rx_run0   (i_run_rx[0]),
      .i_tx_run0   (i_run_tx[0]),
      .i_tx_data   (i_tx_data),
      .i_bb_tx     (i_bb_tx),
      .o_rx_stb    (o_rx_stb),
      .o_rx_data   (o_rx_data),
      .o_tx        (o_tx)
   );

endmodule

`default_nettype wire

//--- fe_control/fe_control.sv
`default_nettype none
// ----------------------------
// rx and tx front end correction for one slot
// baseband engine samples override the host streams while running
// ----------------------------

module fe_control
   import radio_pkg::*;
#(
   parameter set_addr_t SR_RX_FE_BASE     = 8'd224,
   parameter set_addr_t SR_TX_FE_BASE     = 8'd208,
   parameter set_addr_t SR_FE_CHAN_OFFSET = 8'd16,
   parameter int        NUM_CHANNELS      = 2
) (
   input  wire                      radio_clk,
   input  wire                      i_rst_n,
   input  wire set_bus_t            i_set,
   // rx side
   input  wire                      i_rx_stb,
   input  wire sample_t             i_rx_sample,   // adc, shared by all channels
   input  wire sample_t             i_bb_rx,
   input  wire                      i_rx_run0,
   // tx side, runs every cycle
   input  wire                      i_tx_run0,
   input  wire sample_t             i_tx_data,
   input  wire sample_t             i_bb_tx,
   output logic                     o_rx_stb,
   output sample_t [NUM_CHANNELS-1:0] o_rx_data,
   output sample_t                  o_tx
);

   logic [NUM_CHANNELS-1:0] rx_stb_ch;   // per channel strobe
   sample_t                 tx_pre;      // tx sample before correction

   // ----------------------------
   // rx channels
   // ----------------------------
   for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_rx
      fe_iq_corrector #(
         .SR_BASE(set_addr_t'(SR_RX_FE_BASE + c * SR_FE_CHAN_OFFSET))
      ) rx_corr_i (
         .radio_clk       (radio_clk),
         .i_rst_n         (i_rst_n),
         .i_set           (i_set),
         .i_stb           (i_rx_stb),
         .i_sample        (i_rx_sample),
         .i_bypass_en     (i_rx_run0),    // bb stream goes to host as is
         .i_bypass_sample (i_bb_rx),
         .o_stb           (rx_stb_ch[c]),
         .o_sample        (o_rx_data[c])
      );
   end

   assign o_rx_stb = rx_stb_ch[0];

   // ----------------------------
   // tx, channel 0 only reaches the dac
   // ----------------------------
   assign tx_pre = i_tx_run0 ? i_bb_tx : i_tx_data;   // override before correction

   fe_iq_corrector #(
      .SR_BASE(SR_TX_FE_BASE)
   ) tx_corr_i (
      .radio_clk       (radio_clk),
      .i_rst_n         (i_rst_n),
      .i_set           (i_set),
      .i_stb           (1'b1),
      .i_sample        (tx_pre),
      .i_bypass_en     (1'b0),
      .i_bypass_sample ('0),
      .o_stb           (),
      .o_sample        (o_tx)
   );

endmodule

`default_nettype wire

//--- fe_control/fe_iq_corrector.sv
`default_nettype none
// ----------------------------
// one channel of i/q correction, swap then negate i then dc add
// ----------------------------

module fe_iq_corrector
   import radio_pkg::*;
#(
   parameter set_addr_t SR_BASE = 8'd224
) (
   input  wire           radio_clk,
   input  wire           i_rst_n,
   input  wire set_bus_t i_set,
   input  wire           i_stb,             // sample valid
   input  wire sample_t  i_sample,
   input  wire           i_bypass_en,       // pass bypass sample untouched
   input  wire sample_t  i_bypass_sample,
   output logic          o_stb,
   output sample_t       o_sample
);

   set_addr_t  fe_off;   // address relative to channel window
   iq_t        dc_i;
   iq_t        dc_q;
   logic [1:0] ctrl;     // swap, invert i
   iq_t        in_i;
   iq_t        in_q;
   iq_t        sw_i;
   iq_t        sw_q;
   iq_t        neg_i;
   iq_t        corr_i;
   iq_t        corr_q;

   assign fe_off = i_set.addr - SR_BASE;

   // channel registers
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         dc_i <= '0;
         dc_q <= '0;
         ctrl <= '0;
      end else if (i_set.stb) begin
         if (fe_off == SR_FE_DC) begin
            dc_i <= i_set.data[31:16];
            dc_q <= i_set.data[15:0];
         end
         if (fe_off == SR_FE_CTRL) begin
            ctrl <= i_set.data[1:0];
         end
      end
   end

   // ----------------------------
   // datapath, all 16 bit wrap
   // ----------------------------
   assign in_i   = i_sample[31:16];
   assign in_q   = i_sample[15:0];
   assign sw_i   = ctrl[FE_CTRL_SWAP] ? in_q : in_i;
   assign sw_q   = ctrl[FE_CTRL_SWAP] ? in_i : in_q;
   assign neg_i  = ctrl[FE_CTRL_INV_I] ? -sw_i : sw_i;   // -32768 stays put
   assign corr_i = neg_i + dc_i;
   assign corr_q = sw_q + dc_q;

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_stb    <= 1'b0;
         o_sample <= '0;
      end else begin
         o_stb <= i_stb;
         if (i_stb) begin
            o_sample <= i_bypass_en ? i_bypass_sample : {corr_i, corr_q};
         end
      end
   end

   // sample and bypass select defined whenever strobed
   a_sample_known: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      i_stb |-> !$isunknown({i_bypass_en, i_sample}))
      else $error("corrector strobed with unknown sample");

endmodule

`default_nettype wire

//--- db_control/db_atr_gpio.sv
`default_nettype none
// ----------------------------
// atr state from the channel run flags, picks gpio and led banks
// ----------------------------

module db_atr_gpio
   import radio_pkg::*;
#(
   parameter int NUM_CHANNELS = 2
) (
   input  wire                    radio_clk,
   input  wire                    i_rst_n,
   input  wire [NUM_CHANNELS-1:0] i_run_rx,      // level per channel
   input  wire [NUM_CHANNELS-1:0] i_run_tx,
   input  wire word_t [3:0]       i_gpio_bank,
   input  wire led_t  [3:0]       i_led_bank,
   output word_t                  o_gpio_out,
   output led_t                   o_leds
);

   logic       run_rx_any;   // any rx channel streaming
   logic       run_tx_any;
   atr_state_t atr_state;

   // one slot, so channels can't drive gpio separately
   assign run_rx_any = |i_run_rx;
   assign run_tx_any = |i_run_tx;

   always_comb begin
      case ({run_tx_any, run_rx_any})
         2'b01:   atr_state = ATR_RX;
         2'b10:   atr_state = ATR_TX;
         2'b11:   atr_state = ATR_FULL_DUPLEX;
         default: atr_state = ATR_IDLE;
      endcase
   end

   // ----------------------------
   // registered pin outputs
   // ----------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_gpio_out <= '0;
         o_leds     <= '0;   // leds off
      end else begin
         o_gpio_out <= i_gpio_bank[atr_state];
         o_leds     <= i_led_bank[atr_state];
      end
   end

   // run flags come from outside the slot
   a_atr_known: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      !$isunknown({run_tx_any, run_rx_any}))
      else $error("atr state unknown, check run flags");

endmodule

`default_nettype wire

//--- db_control/db_settings_regs.sv
`default_nettype none
// ----------------------------
// daughterboard register file, written from the settings bus
// also answers readback requests with one cycle latency
// ----------------------------

module db_settings_regs
   import radio_pkg::*;
#(
   parameter set_addr_t SR_DB_BASE = 8'd160
) (
   input  wire             radio_clk,
   input  wire             i_rst_n,
   // settings and readback
   input  wire set_bus_t   i_set,
   input  wire rb_req_t    i_rb,
   // pin and status inputs
   input  wire word_t      i_gpio_in,
   input  wire word_t      i_misc_in,
   input  wire word_t      i_gpio_out,    // current atr output, for readback
   input  wire led_t       i_leds,
   // register contents
   output word_t [3:0]     o_gpio_bank,   // indexed by atr_state_t
   output led_t  [3:0]     o_led_bank,
   output word_t           o_gpio_ddr,
   output word_t           o_misc_out,
   output logic            o_rb_stb,
   output rb_data_t        o_rb_data
);

   set_addr_t  db_off;       // address relative to db window
   logic [1:0] led_idx;      // led bank select
   word_t      misc_out_r;   // misc out register, as written
   word_t      misc_in_r;    // misc in, one stage

   // wraps for addresses below base, lands outside the map
   assign db_off  = i_set.addr - SR_DB_BASE;
   assign led_idx = 2'(db_off - SR_LED_IDLE);

   // ----------------------------
   // settings writes
   // ----------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_gpio_bank <= '0;
         o_led_bank  <= '0;
         o_gpio_ddr  <= '0;   // all pins inputs out of reset
         misc_out_r  <= '0;
      end else if (i_set.stb) begin
         case (db_off)
            SR_GPIO_IDLE, SR_GPIO_RX, SR_GPIO_TX, SR_GPIO_FDX: begin
               o_gpio_bank[db_off[1:0]] <= i_set.data;
            end
            SR_GPIO_DDR: begin
               o_gpio_ddr <= i_set.data;
            end
            SR_MISC_OUT: begin
               misc_out_r <= i_set.data;
            end
            SR_LED_IDLE, SR_LED_RX, SR_LED_TX, SR_LED_FDX: begin
               o_led_bank[led_idx] <= i_set.data[2:0];
            end
            default: begin
               // not ours, fe registers or another block
            end
         endcase
      end
   end

   // misc pins, one register each way
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         misc_in_r  <= '0;
         o_misc_out <= '0;
      end else begin
         misc_in_r  <= i_misc_in;
         o_misc_out <= misc_out_r;
      end
   end

   // ----------------------------
   // readback
   // ----------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rb_stb  <= 1'b0;
         o_rb_data <= '0;
      end else begin
         o_rb_stb <= i_rb.stb;
         if (i_rb.stb) begin
            case (i_rb.addr)
               RB_GPIO:    o_rb_data <= {i_gpio_in, i_gpio_out};
               RB_MISC:    o_rb_data <= {misc_in_r, misc_out_r};
               RB_DDR_LED: o_rb_data <= {o_gpio_ddr, 29'd0, i_leds};
               default:    o_rb_data <= '0;
            endcase
         end
      end
   end

   // request from the host side, strobe and address defined
   a_rb_req_known: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      !$isunknown(i_rb.stb) && (!i_rb.stb || !$isunknown(i_rb.addr)))
      else $error("readback request unknown");

endmodule

`default_nettype wire

//--- common/radio_pkg.sv
`default_nettype none
// ----------------------------
// types, register offsets and bus structs shared by the radio slot
// modules pull it in with a wildcard import in their header
// ----------------------------

package radio_pkg;

   // ----------------------------
   // widths with a meaning
   // ----------------------------
   typedef logic [7:0]         set_addr_t;   // settings and readback address
   typedef logic [31:0]        word_t;       // settings data, gpio, misc
   typedef logic [63:0]        rb_data_t;    // readback word
   typedef logic signed [15:0] iq_t;         // one i or q component
   typedef logic [31:0]        sample_t;     // i in [31:16], q in [15:0]
   typedef logic [2:0]         led_t;        // {rx, txrx_tx, txrx_rx}

   // settings write, valid while stb high
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      word_t     data;
   } set_bus_t;

   // readback request, answered one cycle later
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
   } rb_req_t;

   // encoding is {tx, rx} so it doubles as the bank index
   typedef enum logic [1:0] {
      ATR_IDLE        = 2'd0,
      ATR_RX          = 2'd1,
      ATR_TX          = 2'd2,
      ATR_FULL_DUPLEX = 2'd3
   } atr_state_t;

   // ----------------------------
   // db register offsets
   // ----------------------------
   localparam set_addr_t SR_GPIO_IDLE = 8'd0;
   localparam set_addr_t SR_GPIO_RX   = 8'd1;
   localparam set_addr_t SR_GPIO_TX   = 8'd2;
   localparam set_addr_t SR_GPIO_FDX  = 8'd3;
   localparam set_addr_t SR_GPIO_DDR  = 8'd4;   // 1 = pin driven
   localparam set_addr_t SR_MISC_OUT  = 8'd5;
   localparam set_addr_t SR_LED_IDLE  = 8'd6;
   localparam set_addr_t SR_LED_RX    = 8'd7;
   localparam set_addr_t SR_LED_TX    = 8'd8;
   localparam set_addr_t SR_LED_FDX   = 8'd9;

   // front end, per channel window
   localparam set_addr_t SR_FE_DC   = 8'd0;   // {i offset, q offset}
   localparam set_addr_t SR_FE_CTRL = 8'd1;
   localparam int FE_CTRL_SWAP  = 0;          // ctrl bit, swap i and q
   localparam int FE_CTRL_INV_I = 1;          // ctrl bit, negate i

   // readback addresses, anything else reads zero
   localparam set_addr_t RB_GPIO    = 8'd0;   // {gpio in, gpio out}
   localparam set_addr_t RB_MISC    = 8'd1;   // {misc in, misc out}
   localparam set_addr_t RB_DDR_LED = 8'd2;   // {ddr, leds}

endpackage

`default_nettype wire
